//--- mem_stage.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/lsu_ctrl.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/data_ram.sv
rtl/wb_select.sv
rtl/mem_stage.sv
tb/tb_clkgen.sv
tb/mem_stage_checker.sv
tb/mem_stage_tb.sv

//--- rtl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module data_ram (
    input  wire                       clk,
    input  wire                       re,
    input  wire                       we,
    input  wire  [`MEM_DMEM_AW-1:0]   addr,
    input  wire  [`MEM_XLEN-1:0]      wdata,
    input  wire  [`MEM_XLEN/8-1:0]    wmask,
    output logic [`MEM_XLEN-1:0]      rdata
);

    localparam int XLEN  = `MEM_XLEN;
    localparam int NB    = XLEN / 8;
    localparam int DEPTH = 1 << `MEM_DMEM_AW;

    // word array, contents undefined after reset
    logic [XLEN-1:0] mem [0:DEPTH-1];

    // byte masked write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < NB; i++) begin
                if (wmask[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, holds while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module load_align
    import mem_pkg::*;
(
    input  wire  mem_op_e         op,
    input  wire  [2:0]            offset,
    input  wire  [`MEM_XLEN-1:0]  rword,
    output logic [`MEM_XLEN-1:0]  ldata
);

    localparam int XLEN = `MEM_XLEN;

    // addressed bytes moved down to lane 0
    logic [XLEN-1:0] lane;

    assign lane = rword >> {offset, 3'b000};

    // **************************************************
    // extension per load type
    // **************************************************

    always_comb begin
        case (op)
            // signed loads
            LB: begin
                ldata = {{(XLEN-8){lane[7]}}, lane[7:0]};
            end
            LH: begin
                ldata = {{(XLEN-16){lane[15]}}, lane[15:0]};
            end
            LW: begin
                ldata = {{(XLEN-32){lane[31]}}, lane[31:0]};
            end
            // unsigned loads
            LBU: begin
                ldata = XLEN'(lane[7:0]);
            end
            LHU: begin
                ldata = XLEN'(lane[15:0]);
            end
            LWU: begin
                ldata = XLEN'(lane[31:0]);
            end
            // whole word, offset is zero
            LD: begin
                ldata = rword;
            end
            default: begin
                ldata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module lsu_ctrl
    import mem_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    // execute side
    input  wire                   ex_valid,
    input  wire  [`MEM_XLEN-1:0]  ex_pc,
    input  wire  [31:0]           ex_inst,
    input  wire  mem_op_e         ex_op,
    input  wire  [`MEM_XLEN-1:0]  ex_alu_result,
    input  wire  [`MEM_XLEN-1:0]  ex_src2,
    output logic                  ex_ready,
    // write-back side
    output logic                  wb_valid,
    input  wire                   wb_ready,
    // data memory enables
    output logic                  ram_re,
    output logic                  ram_we,
    // held item
    output mem_op_e               st_op,
    output logic [`MEM_XLEN-1:0]  st_pc,
    output logic [31:0]           st_inst,
    output logic [`MEM_XLEN-1:0]  st_alu_result,
    output logic [`MEM_XLEN-1:0]  st_src2,
    output logic [2:0]            st_offset
);

    stage_state_e state_q;
    stage_state_e state_d;
    logic         accept;
    logic         depart;

    // **************************************************
    // handshake
    // **************************************************

    // stage holds one item, valid while full
    assign wb_valid = (state_q == FULL);
    // take a new item when empty or when the held one leaves now
    assign ex_ready = (state_q == EMPTY) || wb_ready;
    assign accept   = ex_valid && ex_ready;
    assign depart   = wb_valid && wb_ready;

    // memory access only on acceptance
    // a stalled item never touches the ram
    assign ram_re = accept && is_load(ex_op);
    assign ram_we = accept && is_store(ex_op);

    // **************************************************
    // occupancy fsm
    // **************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            EMPTY: begin
                if (accept) begin
                    state_d = FULL;
                end
            end
            FULL: begin
                // refill in the same cycle keeps it full
                if (depart && !accept) begin
                    state_d = EMPTY;
                end
            end
            default: begin
                state_d = EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= EMPTY;
            st_op   <= NONE;
        end else begin
            state_q <= state_d;
            if (accept) begin
                st_op <= ex_op;
            end
        end
    end

    // payload, loaded on acceptance only
    always_ff @(posedge clk) begin
        if (accept) begin
            st_pc         <= ex_pc;
            st_inst       <= ex_inst;
            st_alu_result <= ex_alu_result;
            st_src2       <= ex_src2;
            // byte offset inside the 64-bit word
            st_offset     <= ex_alu_result[2:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

    // operations seen by the memory stage
    typedef enum logic [`MEM_OP_W-1:0] {
        // no register write
        NONE,
        BRANCH,
        // alu based write-back
        ALU,
        ALUW_LO,
        ALUW_HI,
        LINK,
        CSR,
        // loads
        LB,
        LH,
        LW,
        LBU,
        LHU,
        LWU,
        LD,
        // stores, no register write
        SB,
        SH,
        SW,
        SD
    } mem_op_e;

    // occupancy of the stage register
    typedef enum logic {
        EMPTY,
        FULL
    } stage_state_e;

    // op class helpers
    function automatic logic is_load(input mem_op_e op);
        return op inside {LB, LH, LW, LBU, LHU, LWU, LD};
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

endpackage

`default_nettype wire

//--- rtl/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// **************************************************
// memory stage sizing
// **************************************************

// register and data path width
`define MEM_XLEN 64

// data memory depth, log2 of the number of 64-bit words
// 8 gives 256 words or 2 KiB
`define MEM_DMEM_AW 8

// width of the stage operation code
// room for the 18 operations of mem_op_e
`define MEM_OP_W 5

`endif

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_stage
    import mem_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    // from execute
    input  wire                   ex_valid,
    output logic                  ex_ready,
    input  wire  [`MEM_XLEN-1:0]  ex_pc,
    input  wire  [31:0]           ex_inst,
    input  wire  mem_op_e         ex_op,
    input  wire  [`MEM_XLEN-1:0]  ex_alu_result,
    input  wire  [`MEM_XLEN-1:0]  ex_src2,
    // to write-back
    output logic                  wb_valid,
    input  wire                   wb_ready,
    output logic [`MEM_XLEN-1:0]  wb_pc,
    output logic [31:0]           wb_inst,
    output logic                  rd_wen,
    output logic [4:0]            rd_addr,
    output logic [`MEM_XLEN-1:0]  rd_data
);

    localparam int XLEN = `MEM_XLEN;
    localparam int NB   = XLEN / 8;
    localparam int AW   = `MEM_DMEM_AW;

    logic            ram_re;
    logic            ram_we;
    logic [XLEN-1:0] ram_wdata;
    logic [NB-1:0]   ram_wmask;
    logic [XLEN-1:0] ram_rdata;
    logic [AW-1:0]   ram_addr;

    mem_op_e         st_op;
    logic [XLEN-1:0] st_pc;
    logic [31:0]     st_inst;
    logic [XLEN-1:0] st_alu_result;
    logic [XLEN-1:0] st_src2;
    logic [2:0]      st_offset;

    logic [XLEN-1:0] ld_data;
    logic            sel_wen;
    logic [XLEN-1:0] sel_data;

    // **************************************************
    // control and stage register
    // **************************************************

    lsu_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_inst       (ex_inst),
        .ex_op         (ex_op),
        .ex_alu_result (ex_alu_result),
        .ex_src2       (ex_src2),
        .ex_ready      (ex_ready),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .ram_re        (ram_re),
        .ram_we        (ram_we),
        .st_op         (st_op),
        .st_pc         (st_pc),
        .st_inst       (st_inst),
        .st_alu_result (st_alu_result),
        .st_src2       (st_src2),
        .st_offset     (st_offset)
    );

    // **************************************************
    // memory access, addressed from the incoming item
    // **************************************************

    // word address, upper address bits dropped
    assign ram_addr = ex_alu_result[3 +: AW];

    store_align u_store (
        .op     (ex_op),
        .offset (ex_alu_result[2:0]),
        .src2   (ex_src2),
        .wdata  (ram_wdata),
        .wmask  (ram_wmask)
    );

    data_ram u_ram (
        .clk   (clk),
        .re    (ram_re),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .wmask (ram_wmask),
        .rdata (ram_rdata)
    );

    // read word lines up with the held item
    load_align u_load (
        .op     (st_op),
        .offset (st_offset),
        .rword  (ram_rdata),
        .ldata  (ld_data)
    );

    wb_select u_wb (
        .op         (st_op),
        .pc         (st_pc),
        .alu_result (st_alu_result),
        .src2       (st_src2),
        .ldata      (ld_data),
        .rd_wen     (sel_wen),
        .rd_data    (sel_data)
    );

    // write-back outputs, zero while the stage is empty
    assign wb_pc   = wb_valid ? st_pc : '0;
    assign wb_inst = wb_valid ? st_inst : '0;
    assign rd_wen  = wb_valid && sel_wen;
    // rd field of the held instruction
    assign rd_addr = wb_valid ? st_inst[11:7] : '0;
    assign rd_data = wb_valid ? sel_data : '0;

endmodule

`default_nettype wire

//--- rtl/store_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module store_align
    import mem_pkg::*;
(
    input  wire  mem_op_e             op,
    input  wire  [2:0]                offset,
    input  wire  [`MEM_XLEN-1:0]      src2,
    output logic [`MEM_XLEN-1:0]      wdata,
    output logic [`MEM_XLEN/8-1:0]    wmask
);

    localparam int XLEN = `MEM_XLEN;
    localparam int NB   = XLEN / 8;

    // store data and mask before lane shift
    logic [XLEN-1:0] sized;
    logic [NB-1:0]   base_mask;

    always_comb begin
        sized     = '0;
        base_mask = '0;
        case (op)
            SB: begin
                sized     = XLEN'(src2[7:0]);
                base_mask = NB'(1);
            end
            SH: begin
                sized     = XLEN'(src2[15:0]);
                base_mask = NB'(3);
            end
            SW: begin
                sized     = XLEN'(src2[31:0]);
                base_mask = NB'(15);
            end
            SD: begin
                sized     = src2;
                base_mask = '1;
            end
            // everything else leaves memory alone
            default: begin
                sized     = '0;
                base_mask = '0;
            end
        endcase
    end

    // move to the addressed lane
    // aligned accesses only, so nothing spills past byte 7
    assign wdata = sized << {offset, 3'b000};
    assign wmask = base_mask << offset;

endmodule

`default_nettype wire

//--- rtl/wb_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module wb_select
    import mem_pkg::*;
(
    input  wire  mem_op_e         op,
    input  wire  [`MEM_XLEN-1:0]  pc,
    input  wire  [`MEM_XLEN-1:0]  alu_result,
    input  wire  [`MEM_XLEN-1:0]  src2,
    input  wire  [`MEM_XLEN-1:0]  ldata,
    output logic                  rd_wen,
    output logic [`MEM_XLEN-1:0]  rd_data
);

    localparam int XLEN = `MEM_XLEN;

    // **************************************************
    // destination register value
    // **************************************************

    always_comb begin
        rd_wen  = 1'b1;
        rd_data = '0;
        case (op)
            ALU: begin
                rd_data = alu_result;
            end
            // word ops, low half sign extended
            ALUW_LO: begin
                rd_data = {{(XLEN-32){alu_result[31]}}, alu_result[31:0]};
            end
            // high half of a wide product
            ALUW_HI: begin
                rd_data = {{(XLEN-32){alu_result[XLEN-1]}}, alu_result[XLEN-1:32]};
            end
            // jal / jalr return address
            LINK: begin
                rd_data = pc + XLEN'(4);
            end
            // csr old value comes in on src2
            CSR: begin
                rd_data = src2;
            end
            LB, LH, LW, LBU, LHU, LWU, LD: begin
                rd_data = ldata;
            end
            // none, branch and stores
            default: begin
                rd_wen  = 1'b0;
                rd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- tb/mem_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_stage_checker
    import mem_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  ex_valid,
    input  wire                  ex_ready,
    input  wire [`MEM_XLEN-1:0]  ex_pc,
    input  wire [31:0]           ex_inst,
    input  wire mem_op_e         ex_op,
    input  wire [`MEM_XLEN-1:0]  ex_alu_result,
    input  wire [`MEM_XLEN-1:0]  ex_src2,
    input  wire                  wb_valid,
    input  wire                  wb_ready,
    input  wire [`MEM_XLEN-1:0]  wb_pc,
    input  wire [31:0]           wb_inst,
    input  wire                  rd_wen,
    input  wire [4:0]            rd_addr,
    input  wire [`MEM_XLEN-1:0]  rd_data,
    // high once the stimulus has ended
    input  wire                  done,
    output int                   errors
);

    localparam int XLEN = `MEM_XLEN;
    localparam int AW   = `MEM_DMEM_AW;

    // shadow copy of the data memory
    logic [XLEN-1:0] shadow [0:(1<<AW)-1];

    // expected items with the oldest at the front
    logic [XLEN-1:0] q_pc   [$];
    logic [31:0]     q_inst [$];
    logic            q_wen  [$];
    logic [XLEN-1:0] q_data [$];

    int   stall;
    logic done_seen;

    initial begin
        errors    = 0;
        stall     = 0;
        done_seen = 1'b0;
    end

    // bytes moved by a load or store or zero for other ops
    function automatic int size_of(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            LD, SD: return 8;
            default: return 0;
        endcase
    endfunction

    // **************************************************
    // reference model
    // **************************************************

    // expected {rd_wen, rd_data} of one item
    function automatic logic [XLEN:0] reference_wb(
        input mem_op_e         op,
        input logic [XLEN-1:0] pc,
        input logic [XLEN-1:0] alu,
        input logic [XLEN-1:0] src2,
        input logic [XLEN-1:0] word
    );
        logic [XLEN-1:0] v;
        int              n;
        int              off;
        v   = '0;
        n   = size_of(op);
        off = int'(alu[2:0]);
        case (op)
            ALU: return {1'b1, alu};
            ALUW_LO: return {1'b1, {32{alu[31]}}, alu[31:0]};
            ALUW_HI: return {1'b1, {32{alu[63]}}, alu[63:32]};
            LINK: return {1'b1, pc + 64'd4};
            CSR: return {1'b1, src2};
            LB, LH, LW, LBU, LHU, LWU, LD: begin
                // bytes from the addressed lane down to byte 0
                for (int k = 0; k < n; k++) begin
                    v[8*k +: 8] = word[8*(off+k) +: 8];
                end
                // sign fill for the signed loads only
                if ((op == LB || op == LH || op == LW) && v[8*n-1]) begin
                    for (int k = n; k < 8; k++) begin
                        v[8*k +: 8] = 8'hff;
                    end
                end
                return {1'b1, v};
            end
            default: return '0;
        endcase
    endfunction

    // word after a store of n bytes at off
    function automatic logic [XLEN-1:0] store_merge(
        input logic [XLEN-1:0] word,
        input int              off,
        input int              n,
        input logic [XLEN-1:0] src2
    );
        logic [XLEN-1:0] w;
        w = word;
        for (int k = 0; k < n; k++) begin
            w[8*(off+k) +: 8] = src2[8*k +: 8];
        end
        return w;
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] want);
        if (got !== want) begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, want);
        end
    endtask

    // **************************************************
    // per edge checks
    // **************************************************

    task automatic check_occupancy();
        logic full;
        full = (q_pc.size() != 0);
        compare_value("wb_valid", wb_valid, full);
        // a full stage only takes a new item while the old one leaves
        compare_value("ex_ready", ex_ready, !full || wb_ready);
        if (!wb_valid) begin
            compare_value("rd_wen", rd_wen, '0);
            compare_value("rd_addr", rd_addr, '0);
            compare_value("rd_data", rd_data, '0);
            compare_value("wb_pc", wb_pc, '0);
            compare_value("wb_inst", wb_inst, '0);
        end
    endtask

    task automatic check_departure();
        logic [XLEN-1:0] e_pc;
        logic [31:0]     e_inst;
        logic            e_wen;
        logic [XLEN-1:0] e_data;
        if (q_pc.size() == 0) begin
            errors++;
            $display("an item left the stage but none was outstanding");
        end else begin
            e_pc   = q_pc.pop_front();
            e_inst = q_inst.pop_front();
            e_wen  = q_wen.pop_front();
            e_data = q_data.pop_front();
            compare_value("wb_pc", wb_pc, e_pc);
            compare_value("wb_inst", wb_inst, e_inst);
            compare_value("rd_wen", rd_wen, e_wen);
            compare_value("rd_addr", rd_addr, e_inst[11:7]);
            compare_value("rd_data", rd_data, e_data);
        end
    endtask

    task automatic record_acceptance();
        logic [AW-1:0]   idx;
        logic [XLEN:0]   exp;
        idx = ex_alu_result[3 +: AW];
        // loads see every store accepted before them
        exp = reference_wb(ex_op, ex_pc, ex_alu_result, ex_src2, shadow[idx]);
        q_pc.push_back(ex_pc);
        q_inst.push_back(ex_inst);
        q_wen.push_back(exp[XLEN]);
        q_data.push_back(exp[XLEN-1:0]);
        if (ex_op inside {SB, SH, SW, SD}) begin
            shadow[idx] = store_merge(shadow[idx], int'(ex_alu_result[2:0]),
                                      size_of(ex_op), ex_src2);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            q_pc.delete();
            q_inst.delete();
            q_wen.delete();
            q_data.delete();
            stall = 0;
        end else begin
            check_occupancy();
            // watchdog on an expected item that does not leave
            if (q_pc.size() != 0 && !(wb_valid && wb_ready)) begin
                stall++;
            end else begin
                stall = 0;
            end
            if (stall == 51) begin
                errors++;
                $display("an item stayed in the stage for more than 50 cycles");
            end
            // departure first so a same-cycle refill keeps the order
            if (wb_valid && wb_ready) begin
                check_departure();
            end
            if (ex_valid && ex_ready) begin
                record_acceptance();
            end
            if (done && !done_seen) begin
                done_seen = 1'b1;
                if (q_pc.size() != 0) begin
                    errors++;
                    $display("%0d items never left the stage", q_pc.size());
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_stage_tb
    import mem_pkg::*;
();

    localparam int WIN_BASE  = 40;
    localparam int WIN_WORDS = 16;

    logic                 clk;
    logic                 rst;
    logic                 ex_valid;
    logic                 ex_ready;
    logic [`MEM_XLEN-1:0] ex_pc;
    logic [31:0]          ex_inst;
    mem_op_e              ex_op;
    logic [`MEM_XLEN-1:0] ex_alu_result;
    logic [`MEM_XLEN-1:0] ex_src2;
    logic                 wb_valid;
    logic                 wb_ready;
    logic [`MEM_XLEN-1:0] wb_pc;
    logic [31:0]          wb_inst;
    logic                 rd_wen;
    logic [4:0]           rd_addr;
    logic [`MEM_XLEN-1:0] rd_data;

    logic done;
    logic bp_mode;
    logic timed_out;
    int   tb_errors;
    int   chk_errors;

    mem_op_e st_ops [4] = '{SB, SH, SW, SD};
    mem_op_e ld_ops [7] = '{LB, LBU, LH, LHU, LW, LWU, LD};

    tb_clkgen u_clk (
        .clk (clk),
        .rst (rst)
    );

    mem_stage dut (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_ready      (ex_ready),
        .ex_pc         (ex_pc),
        .ex_inst       (ex_inst),
        .ex_op         (ex_op),
        .ex_alu_result (ex_alu_result),
        .ex_src2       (ex_src2),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .wb_pc         (wb_pc),
        .wb_inst       (wb_inst),
        .rd_wen        (rd_wen),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    mem_stage_checker chk (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_ready      (ex_ready),
        .ex_pc         (ex_pc),
        .ex_inst       (ex_inst),
        .ex_op         (ex_op),
        .ex_alu_result (ex_alu_result),
        .ex_src2       (ex_src2),
        .wb_valid      (wb_valid),
        .wb_ready      (wb_ready),
        .wb_pc         (wb_pc),
        .wb_inst       (wb_inst),
        .rd_wen        (rd_wen),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .done          (done),
        .errors        (chk_errors)
    );

    // access size in bytes, zero for non-memory ops
    function automatic int access_size(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            LD, SD: return 8;
            default: return 0;
        endcase
    endfunction

    // byte address inside the test window
    function automatic logic [63:0] word_addr(input int word, input int off);
        return 64'((WIN_BASE + word) * 8 + off);
    endfunction

    // aligned window address for memory ops, anything for the rest
    function automatic logic [63:0] random_alu(input mem_op_e op);
        int n;
        n = access_size(op);
        if (n == 0) begin
            return {$urandom, $urandom};
        end
        return word_addr($urandom_range(0, WIN_WORDS - 1), $urandom_range(0, 7) & ~(n - 1));
    endfunction

    // **************************************************
    // drive helpers, called 1 ns after an edge
    // **************************************************

    task automatic step_ready();
        if (bp_mode) begin
            wb_ready = ($urandom_range(0, 3) != 0);
        end else begin
            wb_ready = 1'b1;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            step_ready();
        end
    endtask

    // offer one item and wait for its acceptance
    task automatic send(input mem_op_e op, input logic [63:0] alu, output int waited);
        logic accepted;
        accepted = 1'b0;
        waited   = 0;
        if (timed_out) begin
            return;
        end
        ex_valid      = 1'b1;
        ex_op         = op;
        ex_pc         = {$urandom, $urandom} & ~64'h3;
        ex_inst       = $urandom;
        ex_alu_result = alu;
        ex_src2       = {$urandom, $urandom};
        while (!accepted && !timed_out) begin
            @(posedge clk);
            accepted = ex_ready;
            #1;
            step_ready();
            if (!accepted) begin
                waited++;
                if (waited >= 50) begin
                    $display("timeout: item not accepted within 50 cycles");
                    tb_errors++;
                    timed_out = 1'b1;
                end
            end
        end
        ex_valid = 1'b0;
    endtask

    initial begin
        int      waited;
        int      guard;
        int      off;
        mem_op_e op;
        void'($urandom(32'h354a7899));
        ex_valid      = 1'b0;
        ex_pc         = '0;
        ex_inst       = '0;
        ex_op         = NONE;
        ex_alu_result = '0;
        ex_src2       = '0;
        wb_ready      = 1'b1;
        done          = 1'b0;
        bp_mode       = 1'b0;
        timed_out     = 1'b0;
        tb_errors     = 0;

        // wait out reset
        guard = 0;
        while (rst !== 1'b0 && guard < 10) begin
            @(posedge clk);
            guard++;
        end
        if (guard >= 10) begin
            $display("timeout: reset never released");
            tb_errors++;
            timed_out = 1'b1;
        end
        #1;
        // idle stage right after reset
        idle_cycles(2);

        // whole words first so every load reads known bytes
        for (int k = 0; k < WIN_WORDS; k++) begin
            send(SD, word_addr(k, 0), waited);
        end

        // each store size, then every load over the same bytes
        for (int s = 0; s < 4; s++) begin
            off = $urandom_range(0, 7) & ~(access_size(st_ops[s]) - 1);
            send(st_ops[s], word_addr(1, off), waited);
            for (int l = 0; l < 7; l++) begin
                send(ld_ops[l], word_addr(1, off & ~(access_size(ld_ops[l]) - 1)), waited);
            end
        end

        // NONE up to CSR
        for (int o = 0; o <= 6; o++) begin
            send(mem_op_e'(o), {$urandom, $urandom}, waited);
        end

        // random mix with back-pressure and gaps
        bp_mode = 1'b1;
        repeat (300) begin
            op = mem_op_e'($urandom_range(0, 17));
            send(op, random_alu(op), waited);
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles(1);
            end
        end

        // back-to-back stream, one item per cycle
        bp_mode = 1'b0;
        idle_cycles(2);
        repeat (40) begin
            op = mem_op_e'($urandom_range(0, 17));
            send(op, random_alu(op), waited);
            if (waited != 0) begin
                tb_errors++;
                $display("stream item waited %0d cycles for acceptance", waited);
            end
        end

        // drain
        guard = 0;
        while (wb_valid && guard < 50) begin
            idle_cycles(1);
            guard++;
        end
        if (guard >= 50) begin
            $display("timeout: stage did not drain within 50 cycles");
            tb_errors++;
        end
        done = 1'b1;
        idle_cycles(1);

        $display("checker errors: %0d, stimulus errors: %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // reset high over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire
